// ==== accumulatorCalc.f ====
+incdir+design
design/calcDataPkg.sv
design/calcCtrlPkg.sv
design/addSub.sv
design/arrayMultiplier.sv
design/divider.sv
design/accumulatorCalc.sv
test/accumulatorCalcTb.sv

// ==== Bender.yml ====
package:
  name: accumulator_calc

sources:
  - include_dirs:
      - design
    files:
      - design/calcDataPkg.sv
      - design/calcCtrlPkg.sv
      - design/addSub.sv
      - design/arrayMultiplier.sv
      - design/divider.sv
      - design/accumulatorCalc.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/accumulatorCalcTb.sv

// ==== test/accumulatorCalcTb.sv ====
//============================
// Self-checking testbench for the accumulator calculator
// Runs a fixed table, then random operations against a model
//============================
`include "accumulatorCalc_defs.svh"

module accumulatorCalcTb
	import calcDataPkg::*, calcCtrlPkg::*;
();

	localparam int NumRows     = 32;
	localparam int NumRandom   = 64;
	localparam int ClkPeriod   = 4;
	localparam int ResetCycles = 10;

	logic    clk;
	logic    reset;
	opcodeT  opcode;
	operandT operand;
	resultT  result;
	errorT   error;

	// Stimulus table
	opcodeT  tblOp   [NumRows];
	operandT tblOpd  [NumRows];
	resultT  tblRes  [NumRows];
	errorT   tblErr  [NumRows];
	string   tblName [NumRows];

	int errorCount;
	int checkCount;

	// Expected outcome of the step in flight
	logic   pendValid;
	logic   pendReport;
	resultT pendRes;
	errorT  pendErr;
	string  pendName;

	logic [31:0] lcgState;

	accumulatorCalc UUT (
		.clk     (clk),
		.reset   (reset),
		.opcode  (opcode),
		.operand (operand),
		.result  (result),
		.error   (error)
	);

	initial
	begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// Watchdog, reset plus every step plus margin
	initial
	begin
		#((ResetCycles + NumRows + NumRandom + 20) * ClkPeriod);
		$display("Timeout: the test sequence did not complete in time");
		$display("Finished with errors");
		$finish;
	end

	//============================
	// Helpers
	//============================
	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Update rule applied to the accumulator value before the edge
	task automatic predict(input opcodeT op, input operandT opd, input resultT accIn,
		output resultT accOut, output errorT errOut);
		logic [16:0] wide;
		operandT     low;
		low    = accIn[15:0];
		accOut = accIn;
		errOut = 2'b00;
		case (op)
			`CALC_OP_RESET:  accOut = '0;
			`CALC_OP_PRESET: accOut = 32'd1;
			`CALC_OP_ADD:
			begin
				wide      = {1'b0, opd} + {1'b0, low};
				accOut    = {16'h0000, wide[15:0]};
				errOut[0] = wide[16]; // Carry out
			end
			`CALC_OP_SUB:
			begin
				accOut    = {16'h0000, opd - low};
				errOut[0] = (opd < low); // Borrow
			end
			`CALC_OP_MUL:    accOut = resultT'(opd) * resultT'(low);
			`CALC_OP_DIV, `CALC_OP_MOD:
			begin
				if (low == 16'h0000)
					errOut = 2'b10; // Accumulator holds
				else if (op == `CALC_OP_DIV)
					accOut = {16'h0000, opd / low};
				else
					accOut = {16'h0000, opd % low};
			end
			default: ; // Spare codes hold
		endcase
	endtask

	task automatic checkOutputs(input string name, input resultT expRes, input errorT expErr,
		output bit ok);
		checkCount++;
		ok = 1'b1;
		if (result !== expRes || error !== expErr)
		begin
			ok = 1'b0;
			errorCount++;
			$display("[FAIL] %0t: %s gave result %h error %b, expected %h error %b",
				$time, name, result, error, expRes, expErr);
		end
	endtask

	task automatic checkPending();
		bit ok;
		if (pendValid)
		begin
			checkOutputs(pendName, pendRes, pendErr, ok);
			if (pendReport)
				$display("%-28s %s", pendName, ok ? "ok" : "mismatch");
		end
		pendValid = 1'b0;
	endtask

	// Drive one step, check the step before it
	task automatic applyStep(input opcodeT op, input operandT opd, input resultT expRes,
		input errorT expErr, input string name, input bit report);
		@(posedge clk);
		opcode  <= op;
		operand <= opd;
		@(negedge clk);
		checkPending();
		pendValid  = 1'b1;
		pendReport = report;
		pendRes    = expRes;
		pendErr    = expErr;
		pendName   = name;
	endtask

	task automatic flushSteps();
		@(posedge clk);
		opcode  <= `CALC_OP_NOOP;
		operand <= '0;
		@(negedge clk);
		checkPending();
	endtask

	function automatic void setRow(input int idx, input opcodeT op, input operandT opd,
		input resultT res, input errorT err, input string name);
		tblOp[idx]   = op;
		tblOpd[idx]  = opd;
		tblRes[idx]  = res;
		tblErr[idx]  = err;
		tblName[idx] = name;
	endfunction

	//============================
	// Table, expected values by hand
	//============================
	task automatic loadTable();
		setRow(0,  `CALC_OP_PRESET, 16'h1234, 32'h0000_0001, 2'b00, "preset after reset");
		setRow(1,  `CALC_OP_RESET,  16'h5555, 32'h0000_0000, 2'b00, "reset op");
		setRow(2,  `CALC_OP_ADD,    16'h1234, 32'h0000_1234, 2'b00, "add from zero");
		setRow(3,  `CALC_OP_ADD,    16'h0F00, 32'h0000_2134, 2'b00, "add chain");
		setRow(4,  `CALC_OP_ADD,    16'hF000, 32'h0000_1134, 2'b01, "add carry");
		setRow(5,  `CALC_OP_ADD,    16'hEECC, 32'h0000_0000, 2'b01, "add carry to zero");
		setRow(6,  `CALC_OP_SUB,    16'h0005, 32'h0000_0005, 2'b00, "sub from zero");
		setRow(7,  `CALC_OP_SUB,    16'h0003, 32'h0000_FFFE, 2'b01, "sub borrow");
		setRow(8,  `CALC_OP_SUB,    16'hFFFE, 32'h0000_0000, 2'b00, "sub equal");
		setRow(9,  `CALC_OP_PRESET, 16'h0000, 32'h0000_0001, 2'b00, "preset");
		setRow(10, `CALC_OP_ADD,    16'hFFFE, 32'h0000_FFFF, 2'b00, "add to all ones");
		setRow(11, `CALC_OP_MUL,    16'hFFFF, 32'hFFFE_0001, 2'b00, "mul all ones");
		setRow(12, `CALC_OP_NOOP,   16'h0000, 32'hFFFE_0001, 2'b00, "noop holds product");
		setRow(13, `CALC_OP_MUL,    16'h1234, 32'h0000_1234, 2'b00, "mul by one");
		setRow(14, `CALC_OP_MUL,    16'h0100, 32'h0012_3400, 2'b00, "mul shift");
		setRow(15, `CALC_OP_DIV,    16'hD000, 32'h0000_0004, 2'b00, "div exact");
		setRow(16, `CALC_OP_MOD,    16'h000E, 32'h0000_0002, 2'b00, "mod");
		setRow(17, `CALC_OP_DIV,    16'h0007, 32'h0000_0003, 2'b00, "div truncates");
		setRow(18, `CALC_OP_MOD,    16'h0064, 32'h0000_0001, 2'b00, "mod by three");
		setRow(19, `CALC_OP_ADD,    16'h0FFF, 32'h0000_1000, 2'b00, "add sets bit 12");
		// Upper half nonzero, low half zero, so a hold differs from a zero load
		setRow(20, `CALC_OP_MUL,    16'h0010, 32'h0001_0000, 2'b00, "mul empties low half");
		setRow(21, `CALC_OP_DIV,    16'h0042, 32'h0001_0000, 2'b10, "div by zero holds");
		setRow(22, `CALC_OP_MOD,    16'h0099, 32'h0001_0000, 2'b10, "mod by zero holds");
		setRow(23, 4'd7,            16'h1111, 32'h0001_0000, 2'b00, "code 7 clears error");
		setRow(24, `CALC_OP_ADD,    16'h00AB, 32'h0000_00AB, 2'b00, "add after div error");
		setRow(25, `CALC_OP_PRESET, 16'h0000, 32'h0000_0001, 2'b00, "preset again");
		setRow(26, `CALC_OP_ADD,    16'h0009, 32'h0000_000A, 2'b00, "add small");
		setRow(27, 4'd9,            16'hFFFF, 32'h0000_000A, 2'b00, "code 9 holds");
		setRow(28, `CALC_OP_ADD,    16'hFFFF, 32'h0000_0009, 2'b01, "add wraps");
		setRow(29, 4'd12,           16'h0000, 32'h0000_0009, 2'b00, "code 12 clears carry");
		setRow(30, 4'd14,           16'hABCD, 32'h0000_0009, 2'b00, "code 14 holds");
		setRow(31, `CALC_OP_DIV,    16'h0000, 32'h0000_0000, 2'b00, "div zero dividend");
	endtask

	//============================
	// Main sequence
	//============================
	initial
	begin
		bit      ok;
		resultT  modelAcc;
		resultT  expAcc;
		errorT   expErr;
		opcodeT  rOp;
		operandT rOpd;
		int      errorsBefore;

		errorCount = 0;
		checkCount = 0;
		pendValid  = 1'b0;
		pendReport = 1'b0;
		pendRes    = '0;
		pendErr    = '0;
		pendName   = "";
		lcgState   = 32'h35cb;
		reset      = 1'b1;
		opcode     = `CALC_OP_NOOP;
		operand    = '0;
		loadTable();

		repeat (ResetCycles) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkOutputs("after reset", '0, '0, ok);
		$display("%-28s %s", "after reset", ok ? "ok" : "mismatch");

		for (int i = 0; i < NumRows; i++)
			applyStep(tblOp[i], tblOpd[i], tblRes[i], tblErr[i], tblName[i], 1'b1);
		flushSteps();

		// Random mix, model starts from the last table value
		modelAcc     = tblRes[NumRows - 1];
		errorsBefore = errorCount;
		for (int i = 0; i < NumRandom; i++)
		begin
			lcgState = nextRandom(lcgState);
			rOp      = lcgState[31:28];
			lcgState = nextRandom(lcgState);
			rOpd     = lcgState[31:16];
			predict(rOp, rOpd, modelAcc, expAcc, expErr);
			modelAcc = expAcc;
			applyStep(rOp, rOpd, expAcc, expErr, $sformatf("random step %0d", i), 1'b0);
		end
		flushSteps();
		$display("%-28s %0d mismatches in %0d steps", "random mix",
			errorCount - errorsBefore, NumRandom);

		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== design/accumulatorCalc.sv ====
//============================
// Accumulator calculator top, one operation per clock
// Result and error are registered, latency of one cycle
//============================
`include "accumulatorCalc_defs.svh"

module accumulatorCalc
	import calcDataPkg::*, calcCtrlPkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  opcodeT  opcode,
	input  operandT operand,
	output resultT  result,
	output errorT   error
);

	resultT  acc;     // Accumulator register
	errorT   errReg;  // Error register
	operandT accLow;  // Low half fed to every unit

	resultT  nextAcc;
	errorT   nextErr;

	logic    subtract;
	operandT diff;
	logic    carryOut;
	resultT  product;
	operandT quotient;
	operandT remainder;
	logic    divByZero;

	assign accLow   = acc[`CALC_OPERAND_WIDTH-1:0];
	assign subtract = (opcode == `CALC_OP_SUB);

	//============================
	// Arithmetic units
	//============================
	addSub uAddSub (
		.a        (operand),
		.b        (accLow),
		.subtract (subtract),
		.diff     (diff),
		.carryOut (carryOut)
	);

	arrayMultiplier uMultiplier (
		.a       (operand),
		.b       (accLow),
		.product (product)
	);

	divider uDivider (
		.dividend  (operand),
		.divisor   (accLow),
		.quotient  (quotient),
		.remainder (remainder),
		.divByZero (divByZero)
	);

	//============================
	// Operation select
	//============================
	always_comb
	begin
		nextErr = '0; // Cleared unless an operation flags it
		case (opcode)
			`CALC_OP_NOOP:   nextAcc = acc;
			`CALC_OP_RESET:  nextAcc = '0;
			`CALC_OP_PRESET: nextAcc = resultT'(1);
			`CALC_OP_ADD:
			begin
				nextAcc    = resultT'(diff);
				nextErr[0] = carryOut;  // Sum overflowed 16 bits
			end
			`CALC_OP_SUB:
			begin
				nextAcc    = resultT'(diff);
				nextErr[0] = ~carryOut; // Borrow, operand below accLow
			end
			`CALC_OP_MUL:    nextAcc = product;
			`CALC_OP_DIV:
			begin
				nextAcc    = divByZero ? acc : resultT'(quotient);
				nextErr[1] = divByZero;
			end
			`CALC_OP_MOD:
			begin
				nextAcc    = divByZero ? acc : resultT'(remainder);
				nextErr[1] = divByZero;
			end
			default:         nextAcc = acc; // Spare codes behave as NO-OP
		endcase
	end

	//============================
	// Registers
	//============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc    <= '0;
			errReg <= '0;
		end
		else
		begin
			acc    <= nextAcc;
			errReg <= nextErr;
		end
	end

	assign result = acc;
	assign error  = errReg;

endmodule

// ==== design/divider.sv ====
//============================
// Unsigned divider giving quotient and remainder together
// Results read zero when divisor is zero
//============================
module divider
	import calcDataPkg::*;
(
	input  operandT dividend,
	input  operandT divisor,
	output operandT quotient,
	output operandT remainder,
	output logic    divByZero
);

	assign divByZero = (divisor == '0);

	always_comb
	begin
		if (divByZero)
		begin
			quotient  = '0; // Not used by the top level
			remainder = '0;
		end
		else
		begin
			quotient  = dividend / divisor;
			remainder = dividend % divisor;
		end
	end

endmodule

// ==== design/arrayMultiplier.sv ====
//============================
// Unsigned 16x16 array multiplier, purely combinational
// Rows of partial-product adders give the 32-bit product
//============================
`include "accumulatorCalc_defs.svh"

module arrayMultiplier
	import calcDataPkg::*;
(
	input  operandT a,
	input  operandT b,
	output resultT  product
);

	localparam int Rows = `CALC_OPERAND_WIDTH - 1; // One adder per partial product after the first

	operandT                      partial [`CALC_OPERAND_WIDTH]; // b gated by each bit of a
	operandT                      augend  [Rows];                // Shifted running sum
	logic [`CALC_OPERAND_WIDTH:0] rowSum  [Rows];                // Carry in the top bit

	genvar i;

	//============================
	// Partial products
	//============================
	generate
		for (i = 0; i < `CALC_OPERAND_WIDTH; i++)
		begin : gPartial
			assign partial[i] = b & {`CALC_OPERAND_WIDTH{a[i]}};
		end
	endgenerate

	//============================
	// Adder ladder
	//============================
	generate
		for (i = 0; i < Rows; i++)
		begin : gRow
			if (i == 0)
			begin : gFirst
				// First row starts from partial zero, its bit 0 already final
				assign augend[i] = {1'b0, partial[0][`CALC_OPERAND_WIDTH-1:1]};
			end
			else
			begin : gNext
				// Carry and upper sum bits of the row above, shifted down one
				assign augend[i] = rowSum[i - 1][`CALC_OPERAND_WIDTH:1];
			end

			assign rowSum[i] = {1'b0, augend[i]} + {1'b0, partial[i + 1]};
		end
	endgenerate

	//============================
	// Product bits
	//============================
	assign product[0] = partial[0][0]; // Straight from the gates

	generate
		for (i = 0; i < Rows - 1; i++)
		begin : gLowBits
			// Each row sheds one finished bit
			assign product[i + 1] = rowSum[i][0];
		end
	endgenerate

	// Last row fills the upper half, carry on top
	assign product[`CALC_RESULT_WIDTH-1:Rows] = rowSum[Rows - 1];

endmodule

// ==== design/addSub.sv ====
//============================
// Ripple-carry adder/subtractor, purely combinational
// subtract high gives a - b in two's complement
//============================
`include "accumulatorCalc_defs.svh"

module addSub
	import calcDataPkg::*;
(
	input  operandT a,
	input  operandT b,
	input  logic    subtract,
	output operandT diff,
	output logic    carryOut
);

	operandT                      bInv;  // b, flipped when subtracting
	logic [`CALC_OPERAND_WIDTH:0] carry; // Ripple chain

	assign bInv     = b ^ {`CALC_OPERAND_WIDTH{subtract}};
	assign carry[0] = subtract; // Plus one completes the negation

	//============================
	// Full-adder cells
	//============================
	genvar i;
	generate
		for (i = 0; i < `CALC_OPERAND_WIDTH; i++)
		begin : gFullAdder
			logic p; // Propagate
			logic g; // Generate

			assign p            = a[i] ^ bInv[i];
			assign g            = a[i] & bInv[i];
			assign diff[i]      = p ^ carry[i];
			assign carry[i + 1] = g | (p & carry[i]);
		end
	endgenerate

	// Low means borrow when subtracting
	assign carryOut = carry[`CALC_OPERAND_WIDTH];

endmodule

// ==== design/calcCtrlPkg.sv ====
//============================
// Control types for opcode and error flags
// Import into modules that decode or report status
//============================
`include "accumulatorCalc_defs.svh"

package calcCtrlPkg;

	// Operation code, compared against the CALC_OP macros
	typedef logic [`CALC_OPCODE_WIDTH-1:0] opcodeT;

	// Bit 1 divide by zero
	// Bit 0 carry on ADD, borrow on SUBTRACT
	typedef logic [1:0] errorT;

endpackage

// ==== design/calcDataPkg.sv ====
//============================
// Data path vector types
// Import into modules that carry operands or results
//============================
`include "accumulatorCalc_defs.svh"

package calcDataPkg;

	// Operand, accumulator low half, unit results
	typedef logic [`CALC_OPERAND_WIDTH-1:0] operandT;

	// Whole accumulator or full product
	typedef logic [`CALC_RESULT_WIDTH-1:0] resultT;

endpackage

// ==== design/accumulatorCalc_defs.svh ====
//============================
// Widths and opcode values shared by the accumulator calculator
// Include wherever a width or opcode is needed
//============================
`ifndef ACCUMULATOR_CALC_DEFS_SVH
`define ACCUMULATOR_CALC_DEFS_SVH

// Data widths
`define CALC_OPERAND_WIDTH 16 // Operand and accumulator low half
`define CALC_RESULT_WIDTH  32 // Full accumulator
`define CALC_OPCODE_WIDTH  4

//============================
// Opcode values
//============================
`define CALC_OP_NOOP   4'd0
`define CALC_OP_RESET  4'd1  // Load zero
`define CALC_OP_ADD    4'd2
`define CALC_OP_SUB    4'd3
`define CALC_OP_MUL    4'd4
`define CALC_OP_DIV    4'd5
`define CALC_OP_MOD    4'd6
`define CALC_OP_PRESET 4'd15 // Load one

`endif
